//--- axi_mem_cfg.svh
// Build-time configuration macros for the banked AXI memory
// AXI widths, bank geometry, bank read latency, R buffer depth
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

// AXI ID width
`define AXI_MEM_ID_W 4

// Byte address width, 4 KiB of memory
`define AXI_MEM_ADDR_W 12

// AXI data width, one beat spans a pair of banks
`define AXI_MEM_DATA_W 64

// Number of SRAM banks
`define AXI_MEM_BANKS 4

// Data width of a single bank
`define AXI_MEM_BANK_DW 32

// Row address width inside one bank
`define AXI_MEM_ROW_W 8

// Bank read latency in cycles, at least 1
`define AXI_MEM_LATENCY 1

// R buffer entries, power of two
`define AXI_MEM_RFIFO_DEPTH 4

`endif

//--- axi_mem_pkg.sv
// Shared types for the banked AXI memory
// Address union, AXI burst and response encodings, busy bit indices
`default_nettype none
`include "axi_mem_cfg.svh"

package axi_mem_pkg;

  // Byte address, used flat for incrementing or split into fields
  // Field order from MSB: bank row, bank pair select, byte in beat
  typedef union packed {
    logic [`AXI_MEM_ADDR_W-1:0] raw;
    struct packed {
      logic [`AXI_MEM_ROW_W-1:0]                row;
      logic                                     pair;
      logic [$clog2(`AXI_MEM_DATA_W / 8)-1:0]  byte_off;
    } f;
  } addr_u;

  // AXI burst type
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // AXI response codes in use
  // EXOKAY and DECERR never produced by this slave
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // Bit positions in the busy status
  // Write busy from AW accept until B handshake
  localparam int unsigned BUSY_WR = 0;
  // Read busy from AR accept until last R handshake
  localparam int unsigned BUSY_RD = 1;

endpackage

`default_nettype wire

//--- bank_req_if.sv
// Wide-beat memory request link between the AXI front end and the bank splitter
// Single-cycle request strobe out, in-order read return strobe back
`default_nettype none
`include "axi_mem_cfg.svh"

interface bank_req_if;

  // Request strobe, never back-pressured
  logic                           req;
  // High for write, low for read
  logic                           we;
  // Beat address
  axi_mem_pkg::addr_u             addr;
  // Full beat of write data and byte enables
  logic [`AXI_MEM_DATA_W-1:0]     wdata;
  logic [`AXI_MEM_DATA_W/8-1:0]   be;

  // Read return strobe and data, in issue order
  logic                           rvalid;
  logic [`AXI_MEM_DATA_W-1:0]     rdata;

  // AXI side issues requests
  modport front (
    output req, we, addr, wdata, be,
    input  rvalid, rdata
  );

  // Bank side consumes requests, returns read data
  modport split (
    input  req, we, addr, wdata, be,
    output rvalid, rdata
  );

endinterface

`default_nettype wire

//--- axi_mem_front.sv
// AXI4 slave protocol engine for the banked memory
// AW/AR round-robin, INCR bursts, SLVERR for FIXED and WRAP,
// credit-counted R buffer and B response
`default_nettype none
`include "axi_mem_cfg.svh"

module axi_mem_front (
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  // AW channel
  input  wire logic                           aw_valid_i,
  input  wire logic [`AXI_MEM_ID_W-1:0]       aw_id_i,
  input  wire logic [`AXI_MEM_ADDR_W-1:0]     aw_addr_i,
  input  wire logic [7:0]                     aw_len_i,
  input  wire logic [1:0]                     aw_burst_i,
  output logic                                aw_ready_o,
  // W channel
  input  wire logic                           w_valid_i,
  input  wire logic [`AXI_MEM_DATA_W-1:0]     w_data_i,
  input  wire logic [`AXI_MEM_DATA_W/8-1:0]   w_strb_i,
  input  wire logic                           w_last_i,
  output logic                                w_ready_o,
  // B channel
  output logic                                b_valid_o,
  output logic [`AXI_MEM_ID_W-1:0]            b_id_o,
  output logic [1:0]                          b_resp_o,
  input  wire logic                           b_ready_i,
  // AR channel
  input  wire logic                           ar_valid_i,
  input  wire logic [`AXI_MEM_ID_W-1:0]       ar_id_i,
  input  wire logic [`AXI_MEM_ADDR_W-1:0]     ar_addr_i,
  input  wire logic [7:0]                     ar_len_i,
  input  wire logic [1:0]                     ar_burst_i,
  output logic                                ar_ready_o,
  // R channel
  output logic                                r_valid_o,
  output logic [`AXI_MEM_ID_W-1:0]            r_id_o,
  output logic [`AXI_MEM_DATA_W-1:0]          r_data_o,
  output logic [1:0]                          r_resp_o,
  output logic                                r_last_o,
  input  wire logic                           r_ready_i,
  // Status
  output logic [1:0]                          busy_o,
  // Memory request link
  bank_req_if.front                           mem
);

  localparam int unsigned DEPTH = `AXI_MEM_RFIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned BEAT_BYTES = `AXI_MEM_DATA_W / 8;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WRITE = 2'd1;
  localparam logic [1:0] ST_READ  = 2'd2;
  localparam logic [1:0] ST_RESP  = 2'd3;

  // Control state
  logic [1:0]                   state_q;
  logic                         rr_q;
  logic                         b_valid_q;
  logic [PTR_W:0]               cred_q;
  logic [PTR_W:0]               wr_ptr_q;
  logic [PTR_W:0]               rd_ptr_q;
  // Burst context
  logic                         err_q;
  logic [`AXI_MEM_ID_W-1:0]     id_q;
  axi_mem_pkg::addr_u           addr_q;
  logic [8:0]                   beats_q;
  logic [7:0]                   push_left_q;
  // R buffer storage
  logic [`AXI_MEM_DATA_W-1:0]   fifo_data_q [DEPTH];
  logic [DEPTH-1:0]             fifo_last_q;

  logic                         aw_hs;
  logic                         ar_hs;
  logic                         w_hs;
  logic                         r_hs;
  logic                         wr_last;
  logic                         rd_issue;
  logic                         push;
  logic [`AXI_MEM_DATA_W-1:0]   push_data;

  // Both ready while idle, one withdrawn on contention by round-robin
  // rr_q high gives the read side priority
  assign aw_ready_o = (state_q == ST_IDLE) && !(ar_valid_i && rr_q);
  assign ar_ready_o = (state_q == ST_IDLE) && !(aw_valid_i && !rr_q);
  assign w_ready_o  = (state_q == ST_WRITE);

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;

  // Final W beat by count from AW len
  assign wr_last = (beats_q == 9'd1);

  // Read issue needs a beat left and a free buffer credit
  assign rd_issue = (state_q == ST_READ) && (beats_q != '0) &&
                    (cred_q < (PTR_W + 1)'(DEPTH));

  // Error reads bypass the banks and push zero beats directly
  assign push      = mem.rvalid || (rd_issue && err_q);
  assign push_data = err_q ? '0 : mem.rdata;

  // Memory request, error bursts never touch the banks
  assign mem.req   = (w_hs || rd_issue) && !err_q;
  assign mem.we    = (state_q == ST_WRITE);
  assign mem.addr  = addr_q;
  assign mem.wdata = w_data_i;
  assign mem.be    = w_strb_i;

  // B channel
  assign b_valid_o = b_valid_q;
  assign b_id_o    = id_q;
  assign b_resp_o  = err_q ? axi_mem_pkg::SLVERR : axi_mem_pkg::OKAY;

  // R channel straight from the buffer head
  assign r_valid_o = (wr_ptr_q != rd_ptr_q);
  assign r_data_o  = fifo_data_q[rd_ptr_q[PTR_W-1:0]];
  assign r_last_o  = fifo_last_q[rd_ptr_q[PTR_W-1:0]];
  assign r_id_o    = id_q;
  assign r_resp_o  = err_q ? axi_mem_pkg::SLVERR : axi_mem_pkg::OKAY;

  assign busy_o[axi_mem_pkg::BUSY_WR] = (state_q == ST_WRITE) || (state_q == ST_RESP);
  assign busy_o[axi_mem_pkg::BUSY_RD] = (state_q == ST_READ);

  // FSM, arbiter, credits and buffer pointers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      rr_q      <= 1'b0;
      b_valid_q <= 1'b0;
      cred_q    <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (aw_hs) begin
            state_q <= ST_WRITE;
            rr_q    <= 1'b1;
          end else if (ar_hs) begin
            state_q <= ST_READ;
            rr_q    <= 1'b0;
          end
        end
        ST_WRITE: begin
          if (w_hs && wr_last) begin
            state_q <= ST_RESP;
          end
        end
        ST_RESP: begin
          // B raised one cycle late so the last write has landed
          if (b_valid_q && b_ready_i) begin
            b_valid_q <= 1'b0;
            state_q   <= ST_IDLE;
          end else begin
            b_valid_q <= 1'b1;
          end
        end
        default: begin
          // Read done once the last beat leaves the buffer
          if (r_hs && r_last_o) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
      // Credits cover buffered beats plus reads in flight
      if (rd_issue && !r_hs) begin
        cred_q <= cred_q + 1'b1;
      end else if (!rd_issue && r_hs) begin
        cred_q <= cred_q - 1'b1;
      end
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (r_hs) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Burst context and buffer contents
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q       <= aw_id_i;
      addr_q.raw <= aw_addr_i;
      err_q      <= (aw_burst_i != axi_mem_pkg::INCR);
      beats_q    <= {1'b0, aw_len_i} + 9'd1;
    end else if (ar_hs) begin
      id_q        <= ar_id_i;
      addr_q.raw  <= ar_addr_i;
      err_q       <= (ar_burst_i != axi_mem_pkg::INCR);
      beats_q     <= {1'b0, ar_len_i} + 9'd1;
      push_left_q <= ar_len_i;
    end else if (w_hs || rd_issue) begin
      // Flat increment wraps modulo the memory size
      addr_q.raw <= addr_q.raw + `AXI_MEM_ADDR_W'(BEAT_BYTES);
      beats_q    <= beats_q - 1'b1;
    end
    // WLAST out of step with AW len turns the burst into SLVERR
    if (w_hs && (w_last_i != wr_last)) begin
      err_q <= 1'b1;
    end
    if (push) begin
      fifo_data_q[wr_ptr_q[PTR_W-1:0]] <= push_data;
      fifo_last_q[wr_ptr_q[PTR_W-1:0]] <= (push_left_q == '0);
      push_left_q                      <= push_left_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- bank_split.sv
// Bank splitter for the banked AXI memory
// Steers a wide beat to one bank pair and regathers read data
`default_nettype none
`include "axi_mem_cfg.svh"

module bank_split (
  input  wire logic                                               clk_i,
  input  wire logic                                               rst_i,
  // Wide request link
  bank_req_if.split                                               mem,
  // Per-bank request vectors
  output logic [`AXI_MEM_BANKS-1:0]                               bank_req_o,
  output logic [`AXI_MEM_BANKS-1:0]                               bank_we_o,
  output logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_ROW_W-1:0]           bank_addr_o,
  output logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_BANK_DW-1:0]         bank_wdata_o,
  output logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_BANK_DW/8-1:0]       bank_be_o,
  // Per-bank read data
  input  wire logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_BANK_DW-1:0]    bank_rdata_i
);

  localparam int unsigned BANKS = `AXI_MEM_BANKS;
  localparam int unsigned DW    = `AXI_MEM_BANK_DW;
  localparam int unsigned BE_W  = `AXI_MEM_BANK_DW / 8;
  localparam int unsigned LAT   = `AXI_MEM_LATENCY;

  // Read tracking pipe with one stage per cycle of bank latency
  logic [LAT-1:0] vld_q;
  logic [LAT-1:0] pair_q;

  // Read access presented to the banks this cycle
  logic           acc_rd;
  logic           acc_pair;

  // The pair field enables two banks per beat
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bank_req_o <= '0;
    end else begin
      for (int b = 0; b < BANKS; b++) begin
        bank_req_o[b] <= mem.req && ((b / 2) == int'(mem.addr.f.pair));
      end
    end
  end

  // Request payload
  // Even bank takes the low half of the beat and odd bank the high half
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < BANKS; b++) begin
      bank_we_o[b]    <= mem.we;
      bank_addr_o[b]  <= mem.addr.f.row;
      bank_wdata_o[b] <= mem.wdata[(b % 2) * DW +: DW];
      bank_be_o[b]    <= mem.be[(b % 2) * BE_W +: BE_W];
    end
  end

  // Decode the access currently at the banks
  assign acc_rd   = |(bank_req_o & ~bank_we_o);
  assign acc_pair = |bank_req_o[BANKS-1:BANKS/2];

  // Valid pipe marks the reads in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= acc_rd;
      for (int s = 1; s < LAT; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  // Pair select follows its valid bit
  always_ff @(posedge clk_i) begin
    pair_q[0] <= acc_pair;
    for (int s = 1; s < LAT; s++) begin
      pair_q[s] <= pair_q[s-1];
    end
  end

  // Each read returns LAT cycles after its bank access
  assign mem.rvalid = vld_q[LAT-1];
  assign mem.rdata  = {bank_rdata_i[{pair_q[LAT-1], 1'b1}],
                       bank_rdata_i[{pair_q[LAT-1], 1'b0}]};

endmodule

`default_nettype wire

//--- sram_bank.sv
// Single-port SRAM bank model
// Byte-masked write, read data through a configurable latency pipe
`default_nettype none
`include "axi_mem_cfg.svh"

module sram_bank (
  input  wire logic                            clk_i,
  input  wire logic                            req_i,
  input  wire logic                            we_i,
  input  wire logic [`AXI_MEM_ROW_W-1:0]       addr_i,
  input  wire logic [`AXI_MEM_BANK_DW-1:0]     wdata_i,
  input  wire logic [`AXI_MEM_BANK_DW/8-1:0]   be_i,
  output logic [`AXI_MEM_BANK_DW-1:0]          rdata_o
);

  localparam int unsigned ROWS = 2 ** `AXI_MEM_ROW_W;
  localparam int unsigned LAT  = `AXI_MEM_LATENCY;

  // Row array, contents undefined until written
  logic [`AXI_MEM_BANK_DW-1:0] mem_q [ROWS];

  // Read latency pipe, last stage drives the output
  logic [`AXI_MEM_BANK_DW-1:0] rd_pipe_q [LAT];

  always_ff @(posedge clk_i) begin
    // Only enabled bytes are updated
    if (req_i && we_i) begin
      for (int b = 0; b < `AXI_MEM_BANK_DW / 8; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    // First stage captures only on a read
    if (req_i && !we_i) begin
      rd_pipe_q[0] <= mem_q[addr_i];
    end
    for (int s = 1; s < LAT; s++) begin
      rd_pipe_q[s] <= rd_pipe_q[s-1];
    end
  end

  assign rdata_o = rd_pipe_q[LAT-1];

endmodule

`default_nettype wire

//--- axi_mem_banked.sv
// Banked AXI4 memory top level
// AXI front end, bank splitter and four SRAM banks
`default_nettype none
`include "axi_mem_cfg.svh"

module axi_mem_banked (
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic                           aw_valid_i,
  input  wire logic [`AXI_MEM_ID_W-1:0]       aw_id_i,
  input  wire logic [`AXI_MEM_ADDR_W-1:0]     aw_addr_i,
  input  wire logic [7:0]                     aw_len_i,
  input  wire logic [1:0]                     aw_burst_i,
  output logic                                aw_ready_o,
  input  wire logic                           w_valid_i,
  input  wire logic [`AXI_MEM_DATA_W-1:0]     w_data_i,
  input  wire logic [`AXI_MEM_DATA_W/8-1:0]   w_strb_i,
  input  wire logic                           w_last_i,
  output logic                                w_ready_o,
  output logic                                b_valid_o,
  output logic [`AXI_MEM_ID_W-1:0]            b_id_o,
  output logic [1:0]                          b_resp_o,
  input  wire logic                           b_ready_i,
  input  wire logic                           ar_valid_i,
  input  wire logic [`AXI_MEM_ID_W-1:0]       ar_id_i,
  input  wire logic [`AXI_MEM_ADDR_W-1:0]     ar_addr_i,
  input  wire logic [7:0]                     ar_len_i,
  input  wire logic [1:0]                     ar_burst_i,
  output logic                                ar_ready_o,
  output logic                                r_valid_o,
  output logic [`AXI_MEM_ID_W-1:0]            r_id_o,
  output logic [`AXI_MEM_DATA_W-1:0]          r_data_o,
  output logic [1:0]                          r_resp_o,
  output logic                                r_last_o,
  input  wire logic                           r_ready_i,
  output logic [1:0]                          busy_o
);

  // Wide link between front end and splitter
  bank_req_if mem_if ();

  // Per-bank wiring
  logic [`AXI_MEM_BANKS-1:0]                          bank_req;
  logic [`AXI_MEM_BANKS-1:0]                          bank_we;
  logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_ROW_W-1:0]      bank_addr;
  logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_BANK_DW-1:0]    bank_wdata;
  logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_BANK_DW/8-1:0]  bank_be;
  logic [`AXI_MEM_BANKS-1:0][`AXI_MEM_BANK_DW-1:0]    bank_rdata;

  // AXI ports map one to one onto the front end
  axi_mem_front u_front (
    .*,
    .mem (mem_if)
  );

  bank_split u_split (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mem          (mem_if),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_be_o    (bank_be),
    .bank_rdata_i (bank_rdata)
  );

  for (genvar b = 0; b < `AXI_MEM_BANKS; b++) begin : g_bank
    sram_bank u_bank (
      .clk_i   (clk_i),
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_addr[b]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

`default_nettype wire

//--- tb_axi_mem_banked.sv
// Testbench for the banked AXI memory
// Random AXI master traffic from a fixed seed, byte-array model with written flags,
// reset, busy and error-burst checks, watchdog
`default_nettype none
`include "axi_mem_cfg.svh"

module tb_axi_mem_banked;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MEM_BYTES = 1 << `AXI_MEM_ADDR_W;
  localparam int unsigned N_SINGLE  = 20;
  localparam int unsigned N_BURST   = 30;
  localparam int unsigned N_ERR     = 6;
  localparam int unsigned N_LONG    = 6;
  localparam int unsigned N_OVL     = 10;
  // Two transactions per pair round, four per error round and three per overlap round
  localparam int unsigned N_TXN = 2 * N_SINGLE + 2 * N_BURST + 4 * N_ERR +
                                  2 * N_LONG + 3 * N_OVL;

  logic                           clk_i;
  logic                           rst_i;
  logic                           aw_valid_i;
  logic [`AXI_MEM_ID_W-1:0]       aw_id_i;
  logic [`AXI_MEM_ADDR_W-1:0]     aw_addr_i;
  logic [7:0]                     aw_len_i;
  logic [1:0]                     aw_burst_i;
  logic                           aw_ready_o;
  logic                           w_valid_i;
  logic [`AXI_MEM_DATA_W-1:0]     w_data_i;
  logic [`AXI_MEM_DATA_W/8-1:0]   w_strb_i;
  logic                           w_last_i;
  logic                           w_ready_o;
  logic                           b_valid_o;
  logic [`AXI_MEM_ID_W-1:0]       b_id_o;
  logic [1:0]                     b_resp_o;
  logic                           b_ready_i;
  logic                           ar_valid_i;
  logic [`AXI_MEM_ID_W-1:0]       ar_id_i;
  logic [`AXI_MEM_ADDR_W-1:0]     ar_addr_i;
  logic [7:0]                     ar_len_i;
  logic [1:0]                     ar_burst_i;
  logic                           ar_ready_o;
  logic                           r_valid_o;
  logic [`AXI_MEM_ID_W-1:0]       r_id_o;
  logic [`AXI_MEM_DATA_W-1:0]     r_data_o;
  logic [1:0]                     r_resp_o;
  logic                           r_last_o;
  logic                           r_ready_i;
  logic [1:0]                     busy_o;

  // Reference memory with a written flag per byte
  bit [7:0] model_mem [MEM_BYTES];
  bit       model_set [MEM_BYTES];

  axi_mem_banked u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] act,
                           input logic [63:0] exp);
    if (act !== exp) begin
      abort($sformatf("FAIL %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  // Aligned beat address drawn from a range of beat indices
  function automatic logic [11:0] rand_addr(input int unsigned lo, input int unsigned hi);
    return {9'($urandom_range(lo, hi)), 3'b000};
  endfunction

  task automatic check_reset_state();
    check_val("b_valid_o", 64'(b_valid_o), 64'd0);
    check_val("r_valid_o", 64'(r_valid_o), 64'd0);
    check_val("busy_o", 64'(busy_o), 64'd0);
  endtask

  // AW, then W beats with random gaps, then B after a random ready delay
  task automatic axi_write(input logic [11:0] addr, input int unsigned len,
                           input logic [1:0] burst, input logic [3:0] id, input bit full);
    logic [63:0] data;
    logic [7:0]  strb;
    logic [11:0] a;
    logic [11:0] ba;
    bit          hs;
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = 8'(len);
    aw_burst_i = burst;
    do begin
      @(negedge clk_i);
      hs = aw_ready_o;
      @(posedge clk_i);
      #10;
    end while (!hs);
    aw_valid_i = 1'b0;
    a = addr;
    for (int unsigned i = 0; i <= len; i++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk_i);
        #10;
      end
      data = {$urandom, $urandom};
      strb = full ? 8'hff : 8'($urandom);
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (i == len);
      do begin
        @(negedge clk_i);
        hs = w_ready_o;
        check_val("busy_o[BUSY_WR]", 64'(busy_o[axi_mem_pkg::BUSY_WR]), 64'd1);
        @(posedge clk_i);
        #10;
      end while (!hs);
      w_valid_i = 1'b0;
      // Only INCR bursts reach memory
      // Bytes walk up from the beat address
      for (int k = 0; k < 8; k++) begin
        ba = a + 12'(k);
        if (strb[0] && burst == axi_mem_pkg::INCR) begin
          model_mem[ba] = data[7:0];
          model_set[ba] = 1'b1;
        end
        strb = strb >> 1;
        data = data >> 8;
      end
      a = a + 12'd8;
    end
    repeat ($urandom_range(0, 3)) begin
      @(posedge clk_i);
      #10;
    end
    b_ready_i = 1'b1;
    do begin
      @(negedge clk_i);
      hs = b_valid_o;
      check_val("busy_o[BUSY_WR]", 64'(busy_o[axi_mem_pkg::BUSY_WR]), 64'd1);
      if (hs) begin
        check_val("b_id_o", 64'(b_id_o), 64'(id));
        check_val("b_resp_o", 64'(b_resp_o), (burst == axi_mem_pkg::INCR) ?
                  64'(axi_mem_pkg::OKAY) : 64'(axi_mem_pkg::SLVERR));
      end
      @(posedge clk_i);
      #10;
    end while (!hs);
    b_ready_i = 1'b0;
  endtask

  // AR, then R beats while r_ready drops for random stretches up to stall cycles
  task automatic axi_read(input logic [11:0] addr, input int unsigned len,
                          input logic [1:0] burst, input logic [3:0] id,
                          input int unsigned stall);
    logic [63:0] exp;
    logic [63:0] mask;
    logic [11:0] a;
    logic [11:0] ba;
    int unsigned beat;
    int unsigned hold;
    bit          hs;
    bit          ok;
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = 8'(len);
    ar_burst_i = burst;
    do begin
      @(negedge clk_i);
      hs = ar_ready_o;
      @(posedge clk_i);
      #10;
    end while (!hs);
    ar_valid_i = 1'b0;
    ok   = (burst == axi_mem_pkg::INCR);
    a    = addr;
    beat = 0;
    hold = 0;
    while (beat <= len) begin
      if (hold > 0) begin
        r_ready_i = 1'b0;
        hold--;
      end else if ($urandom_range(0, 2) == 0) begin
        r_ready_i = 1'b0;
        hold = $urandom_range(0, stall);
      end else begin
        r_ready_i = 1'b1;
      end
      @(negedge clk_i);
      check_val("busy_o[BUSY_RD]", 64'(busy_o[axi_mem_pkg::BUSY_RD]), 64'd1);
      if (r_valid_o && r_ready_i) begin
        // Error beats carry zero data
        // INCR beats compare only the written bytes
        exp  = '0;
        mask = '1;
        if (ok) begin
          for (int k = 0; k < 8; k++) begin
            ba   = a + 12'(k);
            exp  = {model_mem[ba], exp[63:8]};
            mask = {model_set[ba] ? 8'hff : 8'h00, mask[63:8]};
          end
        end
        check_val("r_id_o", 64'(r_id_o), 64'(id));
        check_val("r_resp_o", 64'(r_resp_o),
                  ok ? 64'(axi_mem_pkg::OKAY) : 64'(axi_mem_pkg::SLVERR));
        check_val("r_last_o", 64'(r_last_o), 64'(beat == len));
        check_val("r_data_o", r_data_o & mask, exp & mask);
        a = a + 12'd8;
        beat++;
      end
      @(posedge clk_i);
      #10;
    end
    r_ready_i = 1'b0;
  endtask

  // Watchdog sized from the transaction count
  initial begin
    repeat (200 * N_TXN + 20) @(posedge clk_i);
    abort("Timeout: the tests did not complete within the allowed number of cycles");
  end

  initial begin
    logic [11:0] a;
    logic [11:0] wa;
    int unsigned len;
    int unsigned wlen;
    logic [3:0]  id;
    logic [3:0]  wid;
    logic [1:0]  bt;
    void'($urandom(96));
    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_burst_i = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_burst_i = '0;
    r_ready_i  = 1'b0;
    // Reset state during reset and one cycle after
    for (int c = 0; c < 8; c++) begin
      @(posedge clk_i);
      #10;
      check_reset_state();
    end
    rst_i = 1'b0;
    @(posedge clk_i);
    #10;
    check_reset_state();
    // Single beats with random strobes read back at once under another ID
    for (int n = 0; n < N_SINGLE; n++) begin
      a  = rand_addr(0, 511);
      id = 4'($urandom);
      axi_write(a, 0, axi_mem_pkg::INCR, id, 1'b0);
      axi_read(a, 0, axi_mem_pkg::INCR, ~id, 1);
    end
    // INCR bursts where the final one wraps past the top of memory
    for (int n = 0; n < N_BURST; n++) begin
      len = (n == N_BURST - 1) ? 15 : $urandom_range(0, 15);
      a   = (n == N_BURST - 1) ? 12'hfe8 : rand_addr(0, 511);
      id  = 4'($urandom);
      axi_write(a, len, axi_mem_pkg::INCR, id, 1'b0);
      axi_read(a, len, axi_mem_pkg::INCR, ~id, 1);
    end
    // FIXED and WRAP give SLVERR and leave memory alone
    for (int n = 0; n < N_ERR; n++) begin
      len = $urandom_range(0, 7);
      a   = rand_addr(0, 511);
      id  = 4'($urandom);
      axi_write(a, len, axi_mem_pkg::INCR, id, 1'b1);
      bt = ($urandom_range(0, 1) == 0) ? axi_mem_pkg::FIXED : axi_mem_pkg::WRAP;
      axi_write(a, len, bt, ~id, 1'b0);
      bt = ($urandom_range(0, 1) == 0) ? axi_mem_pkg::FIXED : axi_mem_pkg::WRAP;
      axi_read(a, len, bt, id, 1);
      axi_read(a, len, axi_mem_pkg::INCR, ~id, 1);
    end
    // Long reads under heavy R back-pressure
    for (int n = 0; n < N_LONG; n++) begin
      a  = rand_addr(0, 511);
      id = 4'($urandom);
      axi_write(a, 15, axi_mem_pkg::INCR, id, 1'b1);
      axi_read(a, 15, axi_mem_pkg::INCR, ~id, 12);
    end
    // AW and AR together with the write in the low half and the read in the high half
    for (int n = 0; n < N_OVL; n++) begin
      len  = $urandom_range(0, 15);
      a    = rand_addr(256, 495);
      id   = 4'($urandom);
      wlen = $urandom_range(0, 15);
      wa   = rand_addr(0, 239);
      wid  = 4'($urandom);
      axi_write(a, len, axi_mem_pkg::INCR, id, 1'b0);
      fork
        axi_write(wa, wlen, axi_mem_pkg::INCR, wid, 1'b0);
        axi_read(a, len, axi_mem_pkg::INCR, ~id, 2);
      join
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- axi_mem_banked.f
+incdir+.
axi_mem_pkg.sv
bank_req_if.sv
axi_mem_front.sv
bank_split.sv
sram_bank.sv
axi_mem_banked.sv
tb_axi_mem_banked.sv

//--- run.sh
#!/bin/sh
# Build the banked AXI memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_axi_mem_banked \
  -f axi_mem_banked.f \
  -o sim_axi_mem_banked
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_axi_mem_banked
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
